// File: scan_codes.svh
`ifndef SCAN_CODES_SVH
`define SCAN_CODES_SVH

// make codes, ps/2 set 2 values
`define SC_MAKE_1            8'h16
`define SC_MAKE_2            8'h1E
`define SC_MAKE_3            8'h26
`define SC_MAKE_4            8'h25
`define SC_MAKE_5            8'h2E
`define SC_MAKE_6            8'h36
`define SC_MAKE_7            8'h3D
`define SC_MAKE_8            8'h3E
`define SC_MAKE_F1           8'h05
`define SC_MAKE_F2           8'h06
`define SC_MAKE_N            8'h31
`define SC_MAKE_M            8'h3A
`define SC_MAKE_SPACE        8'h29
`define SC_MAKE_LEFT_ARROW   8'h6B
`define SC_MAKE_RIGHT_ARROW  8'h74
`define SC_MAKE_UP_ARROW     8'h75
`define SC_MAKE_DOWN_ARROW   8'h72

// break codes are the make code with bit 7 set
`define SC_BREAK_1           8'h96
`define SC_BREAK_2           8'h9E
`define SC_BREAK_3           8'hA6
`define SC_BREAK_4           8'hA5
`define SC_BREAK_5           8'hAE
`define SC_BREAK_6           8'hB6
`define SC_BREAK_7           8'hBD
`define SC_BREAK_8           8'hBE
`define SC_BREAK_F1          8'h85
`define SC_BREAK_F2          8'h86
`define SC_BREAK_N           8'hB1
`define SC_BREAK_M           8'hBA
`define SC_BREAK_SPACE       8'hA9
`define SC_BREAK_LEFT_ARROW  8'hEB
`define SC_BREAK_RIGHT_ARROW 8'hF4
`define SC_BREAK_UP_ARROW    8'hF5
`define SC_BREAK_DOWN_ARROW  8'hF2

`endif

// File: dds_pkg.sv
package dds_pkg;

	// ========================================
	// data types
	// ========================================
	typedef logic [11:0] sample_t;     // two's complement sample
	typedef logic [31:0] phase_t;      // accumulator and increment
	typedef logic [3:0]  mod_sel_t;
	typedef logic [7:0]  sig_sel_t;
	typedef logic [7:0]  key_event_t;  // one keyboard event code

	// bit 16 is key 1, bit 0 is the down arrow
	typedef logic [16:0] held_keys_t;

	// ========================================
	// selector codes
	// ========================================
	localparam mod_sel_t MOD_ASK  = 4'd0;
	localparam mod_sel_t MOD_FSK  = 4'd1;
	localparam mod_sel_t MOD_BPSK = 4'd2;
	localparam mod_sel_t MOD_LFSR = 4'd3;

	localparam sig_sel_t SIG_SAW    = 8'd2;
	localparam sig_sel_t SIG_SQUARE = 8'd3;

	// ========================================
	// carrier constants
	// ========================================
	localparam phase_t FIXED_INC   = 32'h0000_0102;  // ask, bpsk, lfsr
	localparam phase_t DEFAULT_INC = 32'h0000_0081;  // unlisted codes

	// square wave rails, full scale positive and negative
	localparam sample_t SQUARE_HIGH = 12'h7FF;
	localparam sample_t SQUARE_LOW  = 12'h800;

	localparam logic [4:0] LFSR_SEED = 5'd1;  // any nonzero start works

endpackage

// File: wave_if.sv
`timescale 1ns/10ps

// carriers and control shared by the execute blocks
interface wave_if;
	import dds_pkg::*;

	phase_t  phase_inc;  // set by the modulator each cycle
	sample_t saw;
	sample_t square;
	logic    lfsr_bit;   // slow pseudo-random data bit

	modport dds (
		input  phase_inc,
		output saw,
		output square
	);

	modport lfsr (
		output lfsr_bit
	);

	modport mod (
		output phase_inc,
		input  saw,
		input  square,
		input  lfsr_bit
	);

endinterface

// File: key_event_decoder.sv
`timescale 1ns/10ps
`include "scan_codes.svh"

module key_event_decoder (
	input  logic                  CLK_25MHZ,
	input  logic                  reset_from_key,
	input  logic                  event_ready,
	input  dds_pkg::key_event_t   event_type,
	output dds_pkg::held_keys_t   held_keys
);
	import dds_pkg::*;

	localparam int num_keys = $bits(held_keys_t);

	// tables listed from bit 16 down to bit 0
	localparam key_event_t make_codes [num_keys-1:0] = '{
		`SC_MAKE_1, `SC_MAKE_2, `SC_MAKE_3, `SC_MAKE_4,
		`SC_MAKE_5, `SC_MAKE_6, `SC_MAKE_7, `SC_MAKE_8,
		`SC_MAKE_F1, `SC_MAKE_F2, `SC_MAKE_N, `SC_MAKE_M, `SC_MAKE_SPACE,
		`SC_MAKE_LEFT_ARROW, `SC_MAKE_RIGHT_ARROW,
		`SC_MAKE_UP_ARROW, `SC_MAKE_DOWN_ARROW
	};
	localparam key_event_t break_codes [num_keys-1:0] = '{
		`SC_BREAK_1, `SC_BREAK_2, `SC_BREAK_3, `SC_BREAK_4,
		`SC_BREAK_5, `SC_BREAK_6, `SC_BREAK_7, `SC_BREAK_8,
		`SC_BREAK_F1, `SC_BREAK_F2, `SC_BREAK_N, `SC_BREAK_M, `SC_BREAK_SPACE,
		`SC_BREAK_LEFT_ARROW, `SC_BREAK_RIGHT_ARROW,
		`SC_BREAK_UP_ARROW, `SC_BREAK_DOWN_ARROW
	};

	held_keys_t set_mask;  // keys pressed this cycle
	held_keys_t clr_mask;  // keys released this cycle

	always_comb
	begin
		set_mask = '0;
		clr_mask = '0;
		for (int k = 0; k < num_keys; k++)
		begin
			set_mask[k] = event_ready && (event_type == make_codes[k]);
			clr_mask[k] = event_ready && (event_type == break_codes[k]);
		end
	end

	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
			held_keys <= '0;
		else
			held_keys <= (held_keys | set_mask) & ~clr_mask;
	end

	// one code never presses and releases the same key
	a_no_make_break_overlap: assert property (@(posedge CLK_25MHZ)
		disable iff (reset_from_key) (set_mask & clr_mask) == '0);

	a_held_keys_known: assert property (@(posedge CLK_25MHZ)
		disable iff (reset_from_key) !$isunknown(held_keys));

endmodule

// File: lfsr_bit_source.sv
`timescale 1ns/10ps

module lfsr_bit_source #(
	parameter int LFSR_DIVIDE = 25_000_000
) (
	input logic CLK_25MHZ,
	input logic reset_from_key,
	wave_if.lfsr wave
);
	import dds_pkg::*;

	localparam int cw = $clog2(LFSR_DIVIDE);
	localparam logic [cw-1:0] last_count = cw'(LFSR_DIVIDE - 1);

	logic [cw-1:0] tick_count;
	logic          tick;        // one cycle in LFSR_DIVIDE
	logic [4:0]    state;

	assign tick = (tick_count == last_count);

	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
		begin
			tick_count <= '0;
			state      <= LFSR_SEED;
		end
		else if (tick)
		begin
			tick_count <= '0;
			state      <= {state[3:0], state[4] ^ state[2]};  // taps 5 and 3
		end
		else
			tick_count <= tick_count + 1'b1;
	end

	assign wave.lfsr_bit = state[0];

	// a zero state would lock the register up
	a_state_nonzero: assert property (@(posedge CLK_25MHZ)
		disable iff (reset_from_key) state != '0);

endmodule

// File: dds_core.sv
`timescale 1ns/10ps

module dds_core (
	input logic CLK_25MHZ,
	input logic reset_from_key,
	wave_if.dds wave
);
	import dds_pkg::*;

	phase_t phase;

	// ========================================
	// phase accumulator
	// ========================================
	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
			phase <= '0;
		else
			phase <= phase + wave.phase_inc;  // wraps at 2^32
	end

	// ========================================
	// carriers
	// ========================================
	// saw is just the top of the phase word
	assign wave.saw = phase[31:20];

	// first half of the period high, second half low
	assign wave.square = phase[31] ? SQUARE_LOW : SQUARE_HIGH;

endmodule

// File: modulator.sv
`timescale 1ns/10ps

module modulator (
	input  dds_pkg::mod_sel_t modulation_selector,
	input  dds_pkg::sig_sel_t signal_selector,
	input  dds_pkg::phase_t   tuning_word,
	wave_if.mod               wave,
	output dds_pkg::sample_t  mod_data,
	output dds_pkg::sample_t  sig_data
);
	import dds_pkg::*;

	sample_t ask_data;   // carrier keyed on and off
	sample_t bpsk_data;  // carrier inverted on zero bits
	phase_t  next_inc;

	assign ask_data  = wave.lfsr_bit ? wave.saw : '0;
	assign bpsk_data = wave.lfsr_bit ? wave.saw : -wave.saw;

	always_comb
	begin
		case (modulation_selector)
			MOD_ASK:
			begin
				mod_data = ask_data;
				next_inc = FIXED_INC;
			end
			MOD_FSK:
			begin
				mod_data = wave.saw;
				next_inc = tuning_word;  // frequency comes from outside
			end
			MOD_BPSK:
			begin
				mod_data = bpsk_data;
				next_inc = FIXED_INC;
			end
			MOD_LFSR:
			begin
				mod_data = {wave.lfsr_bit, 11'b0};  // raw bit as sign
				next_inc = FIXED_INC;
			end
			default:
			begin
				mod_data = ask_data;
				next_inc = DEFAULT_INC;
			end
		endcase
	end

	assign wave.phase_inc = next_inc;

	always_comb
	begin
		case (signal_selector)
			SIG_SQUARE: sig_data = wave.square;
			SIG_SAW:    sig_data = wave.saw;
			default:    sig_data = wave.saw;  // sine is gone, saw stands in
		endcase
	end

endmodule

// File: sample_hold.sv
`timescale 1ns/10ps

module sample_hold #(
	parameter int SAMPLE_DIVIDE = 56_000
) (
	input  logic              CLK_25MHZ,
	input  logic              reset_from_key,
	input  dds_pkg::sample_t  mod_data,
	input  dds_pkg::sample_t  sig_data,
	output dds_pkg::sample_t  mod_sample,
	output dds_pkg::sample_t  sig_sample,
	output logic              sample_strobe
);
	localparam int cw = $clog2(SAMPLE_DIVIDE);
	localparam logic [cw-1:0] last_count = cw'(SAMPLE_DIVIDE - 1);

	logic [cw-1:0] count;    // position in the sample period
	logic          capture;

	assign capture = (count == last_count);

	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
		begin
			count         <= '0;
			mod_sample    <= '0;
			sig_sample    <= '0;
			sample_strobe <= 1'b0;
		end
		else
		begin
			sample_strobe <= capture;  // flags fresh samples
			if (capture)
			begin
				count      <= '0;
				mod_sample <= mod_data;
				sig_sample <= sig_data;
			end
			else
				count <= count + 1'b1;
		end
	end

	a_strobe_single: assert property (@(posedge CLK_25MHZ)
		disable iff (reset_from_key) sample_strobe |=> !sample_strobe);

endmodule

// File: waveform_lab_top.sv
`timescale 1ns/10ps

module waveform_lab_top #(
	parameter int LFSR_DIVIDE   = 25_000_000,  // one lfsr step per second
	parameter int SAMPLE_DIVIDE = 56_000
) (
	input  logic                CLK_25MHZ,
	input  logic                reset_from_key,
	input  logic                event_ready,
	input  dds_pkg::key_event_t event_type,
	input  dds_pkg::phase_t     tuning_word,
	input  dds_pkg::mod_sel_t   modulation_selector,
	input  dds_pkg::sig_sel_t   signal_selector,
	output dds_pkg::held_keys_t held_keys,
	output dds_pkg::sample_t    mod_sample,
	output dds_pkg::sample_t    sig_sample,
	output logic                sample_strobe
);
	import dds_pkg::*;

	sample_t mod_data;
	sample_t sig_data;

	wave_if wave ();

	// ========================================
	// decode
	// ========================================
	key_event_decoder i_key_decoder (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.event_ready    (event_ready),
		.event_type     (event_type),
		.held_keys      (held_keys)
	);

	// ========================================
	// execute
	// ========================================
	lfsr_bit_source #(.LFSR_DIVIDE(LFSR_DIVIDE)) i_lfsr (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.wave           (wave.lfsr)
	);

	dds_core i_dds (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.wave           (wave.dds)
	);

	modulator i_modulator (
		.modulation_selector (modulation_selector),
		.signal_selector     (signal_selector),
		.tuning_word         (tuning_word),
		.wave                (wave.mod),
		.mod_data            (mod_data),
		.sig_data            (sig_data)
	);

	// ========================================
	// result
	// ========================================
	sample_hold #(.SAMPLE_DIVIDE(SAMPLE_DIVIDE)) i_sample_hold (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.mod_data       (mod_data),
		.sig_data       (sig_data),
		.mod_sample     (mod_sample),
		.sig_sample     (sig_sample),
		.sample_strobe  (sample_strobe)
	);

endmodule

// File: waveform_lab_tb.sv
`timescale 1ns/10ps
`include "scan_codes.svh"

module waveform_lab_tb;
	import dds_pkg::*;

	localparam int lfsr_divide    = 7;
	localparam int sample_divide  = 5;
	localparam int n_key_events   = 60;
	localparam int n_quiet_events = 20;  // two events each
	localparam int n_lfsr_strobes = 30;
	localparam int n_sel_strobes  = 20;  // three selections
	localparam int n_mod_strobes  = 40;  // ask and bpsk each
	localparam int test_cycles = 2 * 7 + 2 * (n_key_events + 2 * n_quiet_events)
		+ sample_divide * (n_lfsr_strobes + 3 * n_sel_strobes + 2 * n_mod_strobes);
	localparam int max_cycles = test_cycles + 1000;

	// bit 16 is key 1, bit 0 the down arrow
	localparam key_event_t make_tab [16:0] = '{
		`SC_MAKE_1, `SC_MAKE_2, `SC_MAKE_3, `SC_MAKE_4, `SC_MAKE_5, `SC_MAKE_6,
		`SC_MAKE_7, `SC_MAKE_8, `SC_MAKE_F1, `SC_MAKE_F2, `SC_MAKE_N, `SC_MAKE_M,
		`SC_MAKE_SPACE, `SC_MAKE_LEFT_ARROW, `SC_MAKE_RIGHT_ARROW,
		`SC_MAKE_UP_ARROW, `SC_MAKE_DOWN_ARROW
	};
	localparam key_event_t break_tab [16:0] = '{
		`SC_BREAK_1, `SC_BREAK_2, `SC_BREAK_3, `SC_BREAK_4, `SC_BREAK_5, `SC_BREAK_6,
		`SC_BREAK_7, `SC_BREAK_8, `SC_BREAK_F1, `SC_BREAK_F2, `SC_BREAK_N, `SC_BREAK_M,
		`SC_BREAK_SPACE, `SC_BREAK_LEFT_ARROW, `SC_BREAK_RIGHT_ARROW,
		`SC_BREAK_UP_ARROW, `SC_BREAK_DOWN_ARROW
	};

	logic       CLK_25MHZ;
	logic       reset_from_key;
	logic       event_ready;
	key_event_t event_type;
	phase_t     tuning_word;
	mod_sel_t   modulation_selector;
	sig_sel_t   signal_selector;
	held_keys_t held_keys;
	sample_t    mod_sample;
	sample_t    sig_sample;
	logic       sample_strobe;

	// cycle model state
	phase_t     m_phase;
	int         m_tick;
	logic [4:0] m_lfsr;
	int         m_count;
	logic       m_strobe;
	sample_t    exp_mod;
	sample_t    exp_sig;

	string test_name = "startup";
	int    cycle = 0;
	int    last_strobe = -1;
	int    strobe_count = 0;
	int    errors = 0;
	int    checks = 0;
	int    test_base = 0;
	int    tests_run = 0;
	int    tests_failed = 0;

	waveform_lab_top #(
		.LFSR_DIVIDE   (lfsr_divide),
		.SAMPLE_DIVIDE (sample_divide)
	) i_dut (
		.CLK_25MHZ           (CLK_25MHZ),
		.reset_from_key      (reset_from_key),
		.event_ready         (event_ready),
		.event_type          (event_type),
		.tuning_word         (tuning_word),
		.modulation_selector (modulation_selector),
		.signal_selector     (signal_selector),
		.held_keys           (held_keys),
		.mod_sample          (mod_sample),
		.sig_sample          (sig_sample),
		.sample_strobe       (sample_strobe)
	);

	initial
		CLK_25MHZ = 1'b0;
	always #20 CLK_25MHZ = ~CLK_25MHZ;  // 25 MHz

	// ========================================
	// reference model
	// ========================================
	function automatic phase_t phase_step(input mod_sel_t mode, input phase_t tw);
		if (mode == MOD_FSK)
			return tw;
		if (mode == MOD_ASK || mode == MOD_BPSK || mode == MOD_LFSR)
			return FIXED_INC;
		return DEFAULT_INC;
	endfunction

	// mod sample in the upper half, sig sample in the lower half
	function automatic logic [23:0] expected_samples(input mod_sel_t mode, input sig_sel_t sel,
		input phase_t phase, input logic data_bit);
		sample_t saw;
		sample_t sq;
		sample_t m;
		saw = phase[31:20];
		sq  = phase[31] ? SQUARE_LOW : SQUARE_HIGH;
		if (mode == MOD_FSK)
			m = saw;
		else if (mode == MOD_LFSR)
			m = sample_t'(data_bit) << 11;
		else if (mode == MOD_BPSK)
			m = data_bit ? saw : (~saw + 1'b1);
		else
			m = data_bit ? saw : '0;  // ask, also unlisted codes
		return {m, (sel == SIG_SQUARE) ? sq : saw};
	endfunction

	always @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
		begin
			m_phase  <= '0;
			m_tick   <= 0;
			m_lfsr   <= LFSR_SEED;
			m_count  <= 0;
			m_strobe <= 1'b0;
		end
		else
		begin
			m_phase <= m_phase + phase_step(modulation_selector, tuning_word);
			if (m_tick == lfsr_divide - 1)
			begin
				m_tick <= 0;
				m_lfsr <= {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
			end
			else
				m_tick <= m_tick + 1;
			m_strobe <= (m_count == sample_divide - 1);
			if (m_count == sample_divide - 1)
			begin
				m_count <= 0;
				{exp_mod, exp_sig} <= expected_samples(modulation_selector, signal_selector,
					m_phase, m_lfsr[0]);
			end
			else
				m_count <= m_count + 1;
		end
	end

	// ========================================
	// checks
	// ========================================
	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("ERROR %s: %s expected %h, actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge CLK_25MHZ)
	begin
		if (reset_from_key)
			last_strobe = -1;
		else
		begin
			check_value("sample_strobe", 32'(m_strobe), 32'(sample_strobe));
			if (sample_strobe)
			begin
				check_value("mod_sample", 32'(exp_mod), 32'(mod_sample));
				check_value("sig_sample", 32'(exp_sig), 32'(sig_sample));
				if (last_strobe >= 0)
					check_value("strobe spacing", sample_divide, cycle - last_strobe);
				last_strobe = cycle;
				strobe_count++;
			end
		end
	end

	always @(posedge CLK_25MHZ)
	begin
		cycle++;
		if (cycle >= max_cycles)
		begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("tests failed");
			$finish;
		end
	end

	// ========================================
	// stimulus tasks
	// ========================================
	task automatic start_test(input string name);
		test_name = name;
		test_base = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_base)
			$display("test %s: ok", test_name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errors - test_base);
		end
	endtask

	task automatic apply_reset();
		@(posedge CLK_25MHZ);
		#2;
		reset_from_key = 1'b1;
		repeat (5) @(posedge CLK_25MHZ);
		#2;
		reset_from_key = 1'b0;
		@(negedge CLK_25MHZ);
	endtask

	task automatic check_reset_state();
		check_value("held_keys", '0, 32'(held_keys));
		check_value("mod_sample", '0, 32'(mod_sample));
		check_value("sig_sample", '0, 32'(sig_sample));
		check_value("sample_strobe", '0, 32'(sample_strobe));
	endtask

	function automatic logic is_scan_code(input key_event_t code);
		for (int k = 0; k < 17; k++)
			if (code == make_tab[k] || code == break_tab[k])
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic key_event_t unknown_code();
		key_event_t code;
		do
			code = key_event_t'($urandom_range(255, 0));
		while (is_scan_code(code));
		return code;
	endfunction

	// one event, then the falling edge after it lands
	task automatic send_event(input logic ready, input key_event_t code);
		@(posedge CLK_25MHZ);
		#2;
		event_ready = ready;
		event_type  = code;
		@(posedge CLK_25MHZ);
		#2;
		event_ready = 1'b0;
		@(negedge CLK_25MHZ);
	endtask

	task automatic run_key_events();
		held_keys_t exp_keys;
		int         k;
		logic       press;
		exp_keys = '0;
		repeat (n_key_events)
		begin
			k     = $urandom_range(16, 0);
			press = $urandom_range(1, 0);
			send_event(1'b1, press ? make_tab[k] : break_tab[k]);
			exp_keys[k] = press;
			check_value("held_keys", 32'(exp_keys), 32'(held_keys));
		end
		repeat (n_quiet_events)
		begin
			k = $urandom_range(16, 0);
			send_event(1'b0, exp_keys[k] ? break_tab[k] : make_tab[k]);  // would flip the bit
			check_value("held_keys", 32'(exp_keys), 32'(held_keys));
			send_event(1'b1, unknown_code());
			check_value("held_keys", 32'(exp_keys), 32'(held_keys));
		end
	endtask

	task automatic run_strobes(input mod_sel_t mode, input sig_sel_t sel, input phase_t tw,
		input int n);
		int target;
		@(posedge CLK_25MHZ);
		#2;
		modulation_selector = mode;
		signal_selector     = sel;
		tuning_word         = tw;
		target = strobe_count + n;
		wait (strobe_count >= target);
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial
	begin
		phase_t tw;
		void'($urandom(9));
		reset_from_key      = 1'b1;
		event_ready         = 1'b0;
		event_type          = '0;
		tuning_word         = '0;
		modulation_selector = MOD_ASK;
		signal_selector     = SIG_SAW;
		apply_reset();

		start_test("reset");
		check_reset_state();
		end_test();
		start_test("held_keys");
		run_key_events();
		end_test();
		// square keeps sig_sample nonzero going into the reset
		start_test("lfsr_mode");
		run_strobes(MOD_LFSR, SIG_SQUARE, '0, n_lfsr_strobes);
		end_test();
		start_test("mid_run_reset");
		apply_reset();
		check_reset_state();
		end_test();

		// fsk first so the phase is far from zero for ask and bpsk
		start_test("fsk_default_select");
		tw = $urandom();
		run_strobes(MOD_FSK, SIG_SAW, tw, n_sel_strobes);
		run_strobes(MOD_FSK, SIG_SQUARE, tw, n_sel_strobes);
		run_strobes(mod_sel_t'($urandom_range(15, 4)), sig_sel_t'($urandom_range(255, 4)),
			tw, n_sel_strobes);
		end_test();
		start_test("ask");
		run_strobes(MOD_ASK, SIG_SQUARE, tw, n_mod_strobes);
		end_test();
		start_test("bpsk");
		run_strobes(MOD_BPSK, SIG_SAW, tw, n_mod_strobes);
		end_test();

		$display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
dds_pkg.sv
wave_if.sv
key_event_decoder.sv
lfsr_bit_source.sv
dds_core.sv
modulator.sv
sample_hold.sv
waveform_lab_top.sv
waveform_lab_tb.sv

// File: Bender.yml
package:
  name: waveform_lab

sources:
  - include_dirs:
      - .
    files:
      - dds_pkg.sv
      - wave_if.sv
      - key_event_decoder.sv
      - lfsr_bit_source.sv
      - dds_core.sv
      - modulator.sv
      - sample_hold.sv
      - waveform_lab_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - waveform_lab_tb.sv
